/* Makefile */
TOP = tb_muldiv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* muldiv_ctrl.sv */
//********************************************************************
// multiply/divide sequencer
// walks idle, load, run and fix, issues the per-state strobes and
// reports busy and a one-cycle done
//********************************************************************

module muldiv_ctrl (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  logic                   last_i,
    output logic                   load_o,
    output logic                   dp_load_o,
    output logic                   step_mul_o,
    output logic                   step_div_o,
    output logic                   fix_o,
    output logic                   cnt_clr_o,
    output logic                   cnt_en_o,
    output logic                   busy_o,
    output logic                   done_o
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_RUN,
        S_FIX
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   done_q;
    logic   accept;

    // a start during busy is simply dropped
    assign accept = start_i && !busy_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_LOAD;
                end
            end
            S_LOAD: begin
                state_d = S_RUN;
            end
            S_RUN: begin
                if (last_i) begin
                    state_d = S_FIX;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // result register is written on the same edge
            done_q  <= (state_q == S_FIX);
        end
    end

    assign load_o     = accept;
    assign dp_load_o  = (state_q == S_LOAD);
    assign cnt_clr_o  = (state_q == S_LOAD);
    assign cnt_en_o   = (state_q == S_RUN);
    assign step_mul_o = (state_q == S_RUN) && (op_i == OP_MUL);
    assign step_div_o = (state_q == S_RUN) && (op_i == OP_DIV);
    assign fix_o      = (state_q == S_FIX);

    // stays high through the done cycle
    assign busy_o = (state_q != S_IDLE) || done_q;
    assign done_o = done_q;

endmodule

/* muldiv_iter_cnt.sv */
//********************************************************************
// iteration step counter
// flags the last of the ITER_N datapath steps
//********************************************************************

module muldiv_iter_cnt (
    input  logic clk,
    input  logic rst_i,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);
    import muldiv_pkg::*;

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst_i || clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // count reaches ITER_N on the edge that ends this step
    assign last_o = en_i && (cnt_q == CNT_W'(ITER_N - 1));

endmodule

/* muldiv_operand_prep.sv */
//********************************************************************
// operand capture
// registers operand magnitudes and the sign and divide-by-zero
// information that the final correction needs
//********************************************************************

module muldiv_operand_prep (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               load_i,
    input  muldiv_pkg::muldiv_req_t            req_i,
    output logic [muldiv_pkg::XLEN-1:0]        mag_x_o,
    output logic [muldiv_pkg::XLEN-1:0]        mag_y_o,
    output muldiv_pkg::sign_info_t             sign_o
);
    import muldiv_pkg::*;

    logic       x_neg;
    logic       y_neg;
    sign_info_t sign_d;

    // only a signed operand can be negative
    assign x_neg = !req_i.x_unsigned && req_i.x[XLEN-1];
    assign y_neg = !req_i.y_unsigned && req_i.y[XLEN-1];

    always_comb begin
        sign_d.op       = req_i.op;
        sign_d.neg_lo   = x_neg ^ y_neg;
        sign_d.neg_rem  = x_neg;
        sign_d.div_zero = (req_i.y == '0);
        sign_d.x_orig   = req_i.x;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sign_o <= '0;
        end else if (load_i) begin
            sign_o <= sign_d;
        end
    end

    // most negative value maps onto itself, still right as unsigned
    always_ff @(posedge clk) begin
        if (load_i) begin
            mag_x_o <= x_neg ? -req_i.x : req_i.x;
            mag_y_o <= y_neg ? -req_i.y : req_i.y;
        end
    end

endmodule

/* muldiv_pkg.sv */
//********************************************************************
// multiply/divide unit shared definitions
// operand widths, iteration count, request and sign records, and the
// 64-bit result word with its multiply and divide views
//********************************************************************

package muldiv_pkg;

    localparam int XLEN   = 32;
    localparam int ITER_N = 32;
    // wide enough to hold ITER_N itself
    localparam int CNT_W  = 6;

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } muldiv_op_e;

    typedef struct packed {
        logic            start;
        muldiv_op_e      op;
        logic            x_unsigned;
        logic            y_unsigned;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
    } muldiv_req_t;

    typedef struct packed {
        muldiv_op_e      op;
        // negate product, or negate quotient
        logic            neg_lo;
        logic            neg_rem;
        logic            div_zero;
        // raw dividend, becomes the remainder on divide by zero
        logic [XLEN-1:0] x_orig;
    } sign_info_t;

    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } mul_res_t;

    typedef struct packed {
        logic [XLEN-1:0] rem;
        logic [XLEN-1:0] quo;
    } div_res_t;

    typedef union packed {
        mul_res_t prod;
        div_res_t divres;
    } muldiv_result_u;

endpackage

/* muldiv_result_fix.sv */
//********************************************************************
// result correction and output register
// restores signs, applies the divide-by-zero rule, holds the result
//********************************************************************

module muldiv_result_fix (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          fix_i,
    input  muldiv_pkg::sign_info_t        sign_i,
    input  logic [2*muldiv_pkg::XLEN-1:0] prod_i,
    input  logic [muldiv_pkg::XLEN-1:0]   quo_i,
    input  logic [muldiv_pkg::XLEN-1:0]   rem_i,
    output muldiv_pkg::muldiv_result_u    result_o
);
    import muldiv_pkg::*;

    muldiv_result_u    result_d;
    logic [2*XLEN-1:0] prod_s;
    logic [XLEN-1:0]   quo_s;
    logic [XLEN-1:0]   rem_s;

    // product sign applies to all 64 bits
    assign prod_s = sign_i.neg_lo ? -prod_i : prod_i;

    // quotient and remainder carry separate signs
    assign quo_s = sign_i.neg_lo  ? -quo_i : quo_i;
    assign rem_s = sign_i.neg_rem ? -rem_i : rem_i;

    always_comb begin
        result_d = '0;
        if (sign_i.op == OP_MUL) begin
            result_d.prod = prod_s;
        end else if (sign_i.div_zero) begin
            result_d.divres.quo = '1;
            result_d.divres.rem = sign_i.x_orig;
        end else begin
            result_d.divres.quo = quo_s;
            result_d.divres.rem = rem_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o <= '0;
        end else if (fix_i) begin
            result_o <= result_d;
        end
    end

endmodule

/* muldiv_unit.sv */
//********************************************************************
// iterative 32-bit multiply/divide unit
// start/done handshake, 34 cycles from accept to result
//********************************************************************

module muldiv_unit (
    input  logic                       clk,
    input  logic                       rst_i,
    input  muldiv_pkg::muldiv_req_t    req_i,
    output muldiv_pkg::muldiv_result_u result_o,
    output logic                       done_o,
    output logic                       busy_o
);
    import muldiv_pkg::*;

    // sequencer strobes
    logic load;
    logic dp_load;
    logic step_mul;
    logic step_div;
    logic fix;
    logic cnt_clr;
    logic cnt_en;
    logic last;

    logic [XLEN-1:0]   mag_x;
    logic [XLEN-1:0]   mag_y;
    sign_info_t        sign;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;

    muldiv_ctrl i_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .start_i    (req_i.start),
        .op_i       (sign.op),
        .last_i     (last),
        .load_o     (load),
        .dp_load_o  (dp_load),
        .step_mul_o (step_mul),
        .step_div_o (step_div),
        .fix_o      (fix),
        .cnt_clr_o  (cnt_clr),
        .cnt_en_o   (cnt_en),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    muldiv_iter_cnt i_iter_cnt (
        .clk    (clk),
        .rst_i  (rst_i),
        .clr_i  (cnt_clr),
        .en_i   (cnt_en),
        .last_o (last)
    );

    muldiv_operand_prep i_operand_prep (
        .clk     (clk),
        .rst_i   (rst_i),
        .load_i  (load),
        .req_i   (req_i),
        .mag_x_o (mag_x),
        .mag_y_o (mag_y),
        .sign_o  (sign)
    );

    shift_add_mul i_mul (
        .clk     (clk),
        .rst_i   (rst_i),
        .load_i  (dp_load),
        .step_i  (step_mul),
        .mag_x_i (mag_x),
        .mag_y_i (mag_y),
        .prod_o  (prod)
    );

    restoring_div i_div (
        .clk     (clk),
        .rst_i   (rst_i),
        .load_i  (dp_load),
        .step_i  (step_div),
        .mag_x_i (mag_x),
        .mag_y_i (mag_y),
        .quo_o   (quo),
        .rem_o   (rem)
    );

    muldiv_result_fix i_result_fix (
        .clk      (clk),
        .rst_i    (rst_i),
        .fix_i    (fix),
        .sign_i   (sign),
        .prod_i   (prod),
        .quo_i    (quo),
        .rem_i    (rem),
        .result_o (result_o)
    );

endmodule

/* restoring_div.sv */
//********************************************************************
// radix-2 restoring divider
// produces unsigned quotient and remainder, one quotient bit per step
//********************************************************************

module restoring_div (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        load_i,
    input  logic                        step_i,
    input  logic [muldiv_pkg::XLEN-1:0] mag_x_i,
    input  logic [muldiv_pkg::XLEN-1:0] mag_y_i,
    output logic [muldiv_pkg::XLEN-1:0] quo_o,
    output logic [muldiv_pkg::XLEN-1:0] rem_o
);
    import muldiv_pkg::*;

    logic [XLEN-1:0] rem_q;
    // dividend bits leave at the top, quotient bits enter at the bottom
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dvsr_q;
    logic [XLEN:0]   shifted;
    logic [XLEN+1:0] trial;

    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dvsr_q};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rem_q  <= '0;
            quo_q  <= '0;
            dvsr_q <= '0;
        end else if (load_i) begin
            rem_q  <= '0;
            quo_q  <= mag_x_i;
            dvsr_q <= mag_y_i;
        end else if (step_i) begin
            // sign bit of the trial tells whether the divisor fits
            if (!trial[XLEN+1]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign quo_o = quo_q;
    assign rem_o = rem_q;

endmodule

/* shift_add_mul.sv */
//********************************************************************
// radix-2 shift-and-add multiplier
// builds the unsigned 64-bit product, one multiplier bit per step
//********************************************************************

module shift_add_mul (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          load_i,
    input  logic                          step_i,
    input  logic [muldiv_pkg::XLEN-1:0]   mag_x_i,
    input  logic [muldiv_pkg::XLEN-1:0]   mag_y_i,
    output logic [2*muldiv_pkg::XLEN-1:0] prod_o
);
    import muldiv_pkg::*;

    logic [2*XLEN-1:0] acc_q;
    // multiplicand moves up one place per step
    logic [2*XLEN-1:0] mcand_q;
    logic [XLEN-1:0]   mplier_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            acc_q    <= '0;
            mcand_q  <= '0;
            mplier_q <= '0;
        end else if (load_i) begin
            acc_q    <= '0;
            mcand_q  <= {{XLEN{1'b0}}, mag_x_i};
            mplier_q <= mag_y_i;
        end else if (step_i) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign prod_o = acc_q;

endmodule

/* tb_muldiv.sv */
//**********************************************************************
// testbench for the iterative multiply/divide unit
// xorshift requests checked against a wide-arithmetic model, plus
// latency, busy, ignored-start and back-to-back checks
//**********************************************************************

module tb_muldiv;
    import muldiv_pkg::*;

    localparam int N_REQ      = 400;
    localparam int N_DIRECTED = 14;
    localparam int LATENCY    = 34;
    localparam int MAX_CYCLES = N_REQ * 40 + 2000;

    logic           clk;
    logic           rst_i;
    muldiv_req_t    req;
    muldiv_result_u result;
    logic           done;
    logic           busy;
    logic [31:0]    rng_state = 32'h0dec9833;
    int             cycle_cnt = 0;

    muldiv_unit i_dut (
        .clk      (clk),
        .rst_i    (rst_i),
        .req_i    (req),
        .result_o (result),
        .done_o   (done),
        .busy_o   (busy)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            abort_run($sformatf("timeout: run still going after %0d cycles", MAX_CYCLES));
        end
    end

    // protocol checker bound into the DUT
    always @(negedge clk) begin
        assert (i_dut.i_asserts.fail_cnt == 0)
        else abort_run("a protocol assertion on the DUT failed");
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // corner values now and then, small divisors included
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[3:0])
            4'd0:    return 32'h8000_0000;
            4'd1:    return 32'hffff_ffff;
            4'd2:    return 32'h7fff_ffff;
            4'd3:    return 32'h0000_0001;
            4'd4:    return {28'h0, r[31:28]};
            default: return next_random();
        endcase
    endfunction

    // operands widened to 64 bits, truncating divide, x/0 gives all ones and x
    function automatic muldiv_result_u model_result(input muldiv_req_t r);
        muldiv_result_u res;
        longint         xe;
        longint         ye;
        logic [63:0]    q;
        logic [63:0]    rm;
        xe  = r.x_unsigned ? {32'h0, r.x} : {{32{r.x[31]}}, r.x};
        ye  = r.y_unsigned ? {32'h0, r.y} : {{32{r.y[31]}}, r.y};
        res = '0;
        if (r.op == OP_MUL) begin
            res.prod = xe * ye;
        end else if (r.y == '0) begin
            res.divres.quo = '1;
            res.divres.rem = r.x;
        end else begin
            q              = xe / ye;
            rm             = xe % ye;
            res.divres.quo = q[31:0];
            res.divres.rem = rm[31:0];
        end
        return res;
    endfunction

    task automatic run_request(input string name, input muldiv_op_e op, input logic xu,
                               input logic yu, input logic [31:0] x, input logic [31:0] y,
                               input bit interfere);
        muldiv_req_t    r;
        muldiv_req_t    noise;
        muldiv_result_u exp_res;
        int             cyc;
        r           = '{start: 1'b1, op: op, x_unsigned: xu, y_unsigned: yu, x: x, y: y};
        exp_res     = model_result(r);
        noise       = r;
        noise.start = 1'b0;
        noise.x     = next_random();
        noise.y     = next_random();
        @(posedge clk);
        req <= r;
        @(negedge clk);
        assert (!busy) else abort_run({name, ": unit still busy when the request was issued"});
        // accepting edge, only start matters from here on
        @(posedge clk);
        req <= noise;
        cyc = 0;
        @(negedge clk);
        while (!done) begin
            assert (busy) else abort_run({name, ": busy_o dropped before done_o"});
            assert (cyc < LATENCY) else abort_run({name, ": done_o missing after 34 cycles"});
            @(posedge clk);
            cyc++;
            if (interfere && cyc == 10) begin
                noise.start = 1'b1;
                noise.op    = muldiv_op_e'(!r.op);
                req <= noise;
            end else if (interfere && cyc == 11) begin
                req.start <= 1'b0;
            end
            @(negedge clk);
        end
        check_eq({name, " latency"}, 64'(LATENCY), 64'(cyc));
        assert (busy) else abort_run({name, ": busy_o low in the done cycle"});
        if (op == OP_MUL) begin
            check_eq({name, " product"}, exp_res.prod, result.prod);
        end else begin
            check_eq({name, " quotient"}, {32'h0, exp_res.divres.quo}, {32'h0, result.divres.quo});
            check_eq({name, " remainder"}, {32'h0, exp_res.divres.rem}, {32'h0, result.divres.rem});
        end
        if (interfere) begin
            repeat (LATENCY + 10) begin
                @(negedge clk);
                assert (!done) else abort_run({name, ": start during busy gave a second done_o"});
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] x;
        logic [31:0] y;
        muldiv_op_e  op;
        clk   = 1'b0;
        rst_i = 1'b1;
        req   = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_eq("reset result", 64'h0, result);
        assert (!done && !busy) else abort_run("done_o or busy_o set right after reset");

        // every signed/unsigned flag pair for both operations
        for (int f = 0; f < 4; f++) begin
            x = pick_operand();
            y = pick_operand();
            run_request($sformatf("mul flags %0d", f), OP_MUL, f[0], f[1], x, y, 1'b0);
            x = pick_operand();
            y = pick_operand();
            run_request($sformatf("div flags %0d", f), OP_DIV, f[0], f[1], x, y, 1'b0);
        end
        run_request("div min by -1", OP_DIV, 1'b0, 1'b0, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_request("div -7 by 2", OP_DIV, 1'b0, 1'b0, 32'hffff_fff9, 32'h2, 1'b0);
        run_request("mul min by min", OP_MUL, 1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000, 1'b0);
        run_request("signed div by zero", OP_DIV, 1'b0, 1'b0, next_random() | 32'h8000_0000,
                    32'h0, 1'b0);
        run_request("unsigned div by zero", OP_DIV, 1'b1, 1'b1, next_random(), 32'h0, 1'b0);
        run_request("ignored start", OP_MUL, 1'b0, 1'b0, pick_operand(), pick_operand(), 1'b1);

        for (int i = 0; i < N_REQ - N_DIRECTED; i++) begin
            r  = next_random();
            op = muldiv_op_e'(r[0]);
            x  = pick_operand();
            y  = (op == OP_DIV && i % 16 == 7) ? 32'h0 : pick_operand();
            run_request($sformatf("random %0d", i), op, r[1], r[2], x, y, (i % 20 == 13));
        end

        if (i_dut.i_asserts.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("a protocol assertion on the DUT failed");
        end
    end

endmodule

/* tb_muldiv_asserts.sv */
//**********************************************************************
// protocol assertions for the multiply/divide unit
// done pulse width, quiet outputs in reset, done only while busy
//**********************************************************************

module tb_muldiv_asserts (
    input logic clk,
    input logic rst_i,
    input logic done_i,
    input logic busy_i
);

    int unsigned fail_cnt = 0;

    // done is a single-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_i |=> !done_i)
        else begin
            fail_cnt++;
            $error("done_o stayed high for more than one cycle");
        end

    reset_quiet: assert property (@(posedge clk) rst_i |=> (!done_i && !busy_i))
        else begin
            fail_cnt++;
            $error("done_o or busy_o set after a reset edge");
        end

    // a result only comes out of a running operation
    done_needs_busy: assert property (@(posedge clk) disable iff (rst_i)
        $rose(done_i) |-> $past(busy_i))
        else begin
            fail_cnt++;
            $error("done_o rose while busy_o was low");
        end

endmodule

bind muldiv_unit tb_muldiv_asserts i_asserts (
    .clk    (clk),
    .rst_i  (rst_i),
    .done_i (done_o),
    .busy_i (busy_o)
);

/* vlog.f */
muldiv_pkg.sv
muldiv_ctrl.sv
muldiv_iter_cnt.sv
muldiv_operand_prep.sv
shift_add_mul.sv
restoring_div.sv
muldiv_result_fix.sv
muldiv_unit.sv
tb_muldiv_asserts.sv
tb_muldiv.sv
